// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pe
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/pe_alu.sv
`timescale 1ns/1ps

module pe_alu (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic [pe_isa_pkg::DATA_W-1:0]    ina,
  input  logic [pe_isa_pkg::DATA_W-1:0]    inb,
  input  logic [pe_isa_pkg::DATA_W-1:0]    rf_data,
  pe_ctrl_if.alu                           ctrl,
  output logic [pe_isa_pkg::DATA_W-1:0]    result
);

  logic [pe_isa_pkg::DATA_W-1:0]  a_q;
  logic [pe_isa_pkg::DATA_W-1:0]  b_q;
  logic [pe_isa_pkg::DATA_W-1:0]  b_sel;
  logic [pe_isa_pkg::DATA_W-1:0]  res;
  pe_isa_pkg::alu_op_e            op_q;
  logic                           b_from_rf_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q         <= '0;
      b_q         <= '0;
      op_q        <= pe_isa_pkg::ADD;
      b_from_rf_q <= 1'b0;
    end else if (en) begin
      a_q         <= ina;
      b_q         <= inb;
      op_q        <= ctrl.op;
      b_from_rf_q <= ctrl.b_from_rf;
    end
  end

  // Register data lands in the same cycle as the sampled inputs
  assign b_sel = b_from_rf_q ? rf_data : b_q;

  always_comb begin
    case (op_q)
      pe_isa_pkg::ADD: res = a_q + b_sel;
      pe_isa_pkg::SUB: res = a_q - b_sel;
      pe_isa_pkg::AND: res = a_q & b_sel;
      pe_isa_pkg::OR:  res = a_q | b_sel;
      pe_isa_pkg::XOR: res = a_q ^ b_sel;
      pe_isa_pkg::SHL: res = a_q << b_sel[3:0];
      pe_isa_pkg::SHR: res = a_q >> b_sel[3:0];
      pe_isa_pkg::MUL: res = a_q * b_sel;
      default:         res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (en) begin
      result <= res;
    end
  end

endmodule

// File: logic/pe_conf_if.sv
`timescale 1ns/1ps

interface pe_conf_if;

  logic [pe_isa_pkg::THREAD_W-1:0]     thread;
  logic                                inst_we;
  logic [pe_isa_pkg::PC_W-1:0]         inst_addr;
  pe_isa_pkg::inst_t                   inst_data;
  logic                                const_we;
  logic [pe_isa_pkg::RF_ADDR_W-1:0]    const_addr;
  logic [pe_isa_pkg::DATA_W-1:0]       const_data;
  logic                                loop_we;
  logic [pe_isa_pkg::PC_W-1:0]         pc_max;
  logic [pe_isa_pkg::PC_W-1:0]         pc_loop;
  logic [pe_isa_pkg::IGNORE_W-1:0]     ignore_cnt;

  modport reader (
    output thread, inst_we, inst_addr, inst_data, const_we, const_addr, const_data,
    output loop_we, pc_max, pc_loop, ignore_cnt
  );
  modport ctrl (input thread, inst_we, inst_addr, inst_data, loop_we, pc_max, pc_loop);
  modport rf (input thread, const_we, const_addr, const_data);
  modport out (input thread, loop_we, ignore_cnt);

endinterface

// File: logic/pe_conf_pkg.sv
package pe_conf_pkg;

  localparam int PAYLOAD_W = 28;

  typedef enum logic [1:0] {
    INST  = 2'd0,
    CONST = 2'd1,
    LOOP  = 2'd2
  } conf_kind_e;

  typedef struct packed {
    logic [pe_isa_pkg::PC_W-1:0]       addr;
    pe_isa_pkg::inst_t                 inst;
    logic [7:0]                        pad;
  } conf_inst_t;

  typedef struct packed {
    logic [pe_isa_pkg::RF_ADDR_W-1:0]  addr;
    logic [pe_isa_pkg::DATA_W-1:0]     value;
    logic [8:0]                        pad;
  } conf_const_t;

  typedef struct packed {
    logic [pe_isa_pkg::PC_W-1:0]       pc_max;
    logic [pe_isa_pkg::PC_W-1:0]       pc_loop;
    logic [pe_isa_pkg::IGNORE_W-1:0]   ignore_cnt;
    logic [11:0]                       pad;
  } conf_loop_t;

  // Same 28 payload bits, read according to kind
  typedef union packed {
    conf_inst_t   inst_view;
    conf_const_t  const_view;
    conf_loop_t   loop_view;
  } conf_payload_u;

  typedef struct packed {
    conf_kind_e                        kind;
    logic [pe_isa_pkg::THREAD_W-1:0]   thread;
    conf_payload_u                     payload;
  } conf_word_t;

endpackage

// File: logic/pe_conf_reader.sv
`timescale 1ns/1ps

module pe_conf_reader (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic              conf_req,
  input  logic [31:0]       conf_word,
  output logic              conf_ack,
  pe_conf_if.reader         conf
);

  pe_conf_pkg::conf_word_t  word;
  logic                     take;

  assign word = conf_word;

  // New request seen, write happens on this edge
  assign take = conf_req && !conf_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conf_ack <= 1'b0;
    end else if (take) begin
      conf_ack <= 1'b1;
    end else if (!conf_req) begin
      conf_ack <= 1'b0;
    end
  end

  assign conf.thread     = word.thread;

  assign conf.inst_we    = take && (word.kind == pe_conf_pkg::INST);
  assign conf.inst_addr  = word.payload.inst_view.addr;
  assign conf.inst_data  = word.payload.inst_view.inst;

  assign conf.const_we   = take && (word.kind == pe_conf_pkg::CONST);
  assign conf.const_addr = word.payload.const_view.addr;
  assign conf.const_data = word.payload.const_view.value;

  assign conf.loop_we    = take && (word.kind == pe_conf_pkg::LOOP);
  assign conf.pc_max     = word.payload.loop_view.pc_max;
  assign conf.pc_loop    = word.payload.loop_view.pc_loop;
  assign conf.ignore_cnt = word.payload.loop_view.ignore_cnt;

  // Configuration is only legal while the array is frozen
  a_req_while_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(conf_req) |-> !en)
    else $error("conf_req raised while en is high");

  a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
    conf_req && $past(conf_req) |-> $stable(conf_word))
    else $error("conf_word changed while conf_req is high");

endmodule

// File: logic/pe_control.sv
`timescale 1ns/1ps

module pe_control (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    en,
  pe_conf_if.ctrl conf,
  pe_ctrl_if.ctrl ctrl
);

  logic [pe_isa_pkg::THREAD_W-1:0]   thr;
  logic [pe_isa_pkg::THREAD_W-1:0]   thr_f;
  logic [pe_isa_pkg::THREAD_W-1:0]   thr_d1;
  logic [pe_isa_pkg::THREAD_W-1:0]   thr_d2;
  logic [pe_isa_pkg::PC_W-1:0]       pc        [pe_isa_pkg::NUM_THREADS];
  logic [pe_isa_pkg::PC_W-1:0]       pc_max_r  [pe_isa_pkg::NUM_THREADS];
  logic [pe_isa_pkg::PC_W-1:0]       pc_loop_r [pe_isa_pkg::NUM_THREADS];
  pe_isa_pkg::inst_t                 imem      [pe_isa_pkg::IMEM_DEPTH];
  pe_isa_pkg::inst_t                 inst_q;
  logic                              rf_we_d1, rf_we_d2;
  logic [pe_isa_pkg::RF_ADDR_W-1:0]  waddr_d1, waddr_d2;
  logic                              out_a_d1, out_a_d2;
  logic                              out_b_d1, out_b_d2;
  logic                              fifo_d1, fifo_d2;

  // Thread rotation and per-thread PCs with loop-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thr <= '0;
      for (int t = 0; t < pe_isa_pkg::NUM_THREADS; t++) begin
        pc[t]        <= '0;
        pc_max_r[t]  <= '0;
        pc_loop_r[t] <= '0;
      end
    end else begin
      if (conf.loop_we) begin
        pc_max_r[conf.thread]  <= conf.pc_max;
        pc_loop_r[conf.thread] <= conf.pc_loop;
      end
      if (en) begin
        thr <= thr + 1'b1;
        if (pc[thr] == pc_max_r[thr]) begin
          pc[thr] <= pc_loop_r[thr];
        end else begin
          pc[thr] <= pc[thr] + 1'b1;
        end
      end
    end
  end

  // Unwritten slots decode as an ADD with no side effects
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < pe_isa_pkg::IMEM_DEPTH; i++) begin
        imem[i] <= '0;
      end
    end else if (conf.inst_we) begin
      imem[{conf.thread, conf.inst_addr}] <= conf.inst_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_q <= '0;
      thr_f  <= '0;
    end else if (en) begin
      inst_q <= imem[{thr, pc[thr]}];
      thr_f  <= thr;
    end
  end

  assign ctrl.op        = inst_q.op;
  assign ctrl.b_from_rf = inst_q.b_from_rf;
  assign ctrl.rf_raddr  = inst_q.rf_raddr;
  assign ctrl.rd_thread = thr_f;

  // Two stages take write-back and output fields to the result edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_we_d1 <= 1'b0;
      waddr_d1 <= '0;
      out_a_d1 <= 1'b0;
      out_b_d1 <= 1'b0;
      fifo_d1  <= 1'b0;
      thr_d1   <= '0;
      rf_we_d2 <= 1'b0;
      waddr_d2 <= '0;
      out_a_d2 <= 1'b0;
      out_b_d2 <= 1'b0;
      fifo_d2  <= 1'b0;
      thr_d2   <= '0;
    end else if (en) begin
      rf_we_d1 <= inst_q.rf_we;
      waddr_d1 <= inst_q.rf_waddr;
      out_a_d1 <= inst_q.out_a_en;
      out_b_d1 <= inst_q.out_b_en;
      fifo_d1  <= inst_q.fifo_we;
      thr_d1   <= thr_f;
      rf_we_d2 <= rf_we_d1;
      waddr_d2 <= waddr_d1;
      out_a_d2 <= out_a_d1;
      out_b_d2 <= out_b_d1;
      fifo_d2  <= fifo_d1;
      thr_d2   <= thr_d1;
    end
  end

  assign ctrl.rf_we      = rf_we_d2;
  assign ctrl.rf_waddr   = waddr_d2;
  assign ctrl.wr_thread  = thr_d2;
  assign ctrl.out_a_en   = out_a_d2;
  assign ctrl.out_b_en   = out_b_d2;
  assign ctrl.fifo_we    = fifo_d2;
  assign ctrl.out_thread = thr_d2;

  // Rotation keeps a thread's read and write-back on different steps
  a_no_rw_same_thread: assert property (@(posedge clk) disable iff (!rst_n)
    en && ctrl.rf_we |-> ctrl.rd_thread != ctrl.wr_thread)
    else $error("register read and write-back on thread %0d", ctrl.wr_thread);

endmodule

// File: logic/pe_ctrl_if.sv
`timescale 1ns/1ps

interface pe_ctrl_if;

  // Decode stage
  pe_isa_pkg::alu_op_e                 op;
  logic                                b_from_rf;
  logic [pe_isa_pkg::RF_ADDR_W-1:0]    rf_raddr;
  logic [pe_isa_pkg::THREAD_W-1:0]     rd_thread;

  // Write-back stage
  logic                                rf_we;
  logic [pe_isa_pkg::RF_ADDR_W-1:0]    rf_waddr;
  logic [pe_isa_pkg::THREAD_W-1:0]     wr_thread;

  // Output stage
  logic                                out_a_en;
  logic                                out_b_en;
  logic                                fifo_we;
  logic [pe_isa_pkg::THREAD_W-1:0]     out_thread;

  modport ctrl (
    output op, b_from_rf, rf_raddr, rd_thread,
    output rf_we, rf_waddr, wr_thread,
    output out_a_en, out_b_en, fifo_we, out_thread
  );
  modport alu (input op, b_from_rf);
  modport rf (input rf_raddr, rd_thread, rf_we, rf_waddr, wr_thread);
  modport out (input out_a_en, out_b_en, fifo_we, out_thread);

endinterface

// File: logic/pe_isa_pkg.sv
package pe_isa_pkg;

  localparam int DATA_W      = 16;
  localparam int NUM_THREADS = 4;
  localparam int THREAD_W    = 2;
  localparam int PC_W        = 4;
  localparam int RF_ADDR_W   = 3;
  localparam int IGNORE_W    = 8;

  // 16 instruction words and 8 registers per thread
  localparam int IMEM_DEPTH  = NUM_THREADS << PC_W;
  localparam int RF_DEPTH    = NUM_THREADS << RF_ADDR_W;

  // Shifts use the low four bits of B, MUL keeps the low half
  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    SHL = 3'd5,
    SHR = 3'd6,
    MUL = 3'd7
  } alu_op_e;

  typedef struct packed {
    alu_op_e                op;
    logic                   b_from_rf;
    logic [RF_ADDR_W-1:0]   rf_raddr;
    logic                   rf_we;
    logic [RF_ADDR_W-1:0]   rf_waddr;
    logic                   out_a_en;
    logic                   out_b_en;
    logic                   fifo_we;
    logic [1:0]             spare;
  } inst_t;

endpackage

// File: logic/pe_out_stage.sv
`timescale 1ns/1ps

module pe_out_stage (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic [pe_isa_pkg::DATA_W-1:0]    result,
  pe_conf_if.out                           conf,
  pe_ctrl_if.out                           ctrl,
  output logic [pe_isa_pkg::DATA_W-1:0]    outa,
  output logic [pe_isa_pkg::DATA_W-1:0]    outb,
  output logic [pe_isa_pkg::DATA_W-1:0]    fifo_data,
  output logic                             fifo_we
);

  logic [pe_isa_pkg::IGNORE_W-1:0]  cnt   [pe_isa_pkg::NUM_THREADS];
  logic [pe_isa_pkg::IGNORE_W-1:0]  limit [pe_isa_pkg::NUM_THREADS];
  logic                             reached;
  logic                             fifo_we_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outa      <= '0;
      outb      <= '0;
      fifo_data <= '0;
    end else if (en) begin
      fifo_data <= result;
      if (ctrl.out_a_en) begin
        outa <= result;
      end
      if (ctrl.out_b_en) begin
        outb <= result;
      end
    end
  end

  assign reached = cnt[ctrl.out_thread] == limit[ctrl.out_thread];

  // First N FIFO results of a thread are swallowed by its counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_we_q <= 1'b0;
      for (int t = 0; t < pe_isa_pkg::NUM_THREADS; t++) begin
        cnt[t]   <= '0;
        limit[t] <= '0;
      end
    end else begin
      if (conf.loop_we) begin
        limit[conf.thread] <= conf.ignore_cnt;
        cnt[conf.thread]   <= '0;
      end
      if (en) begin
        fifo_we_q <= ctrl.fifo_we && reached;
        if (ctrl.fifo_we && !reached) begin
          cnt[ctrl.out_thread] <= cnt[ctrl.out_thread] + 1'b1;
        end
      end
    end
  end

  // Consumer sees a write only on advance steps
  assign fifo_we = fifo_we_q && en;

endmodule

// File: logic/pe_regfile.sv
`timescale 1ns/1ps

module pe_regfile (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             en,
  pe_conf_if.rf                            conf,
  pe_ctrl_if.rf                            ctrl,
  input  logic [pe_isa_pkg::DATA_W-1:0]    wr_data,
  output logic [pe_isa_pkg::DATA_W-1:0]    rd_data
);

  logic [pe_isa_pkg::DATA_W-1:0] mem [pe_isa_pkg::RF_DEPTH];

  // Thread index selects the 8-entry slice
  always_ff @(posedge clk) begin
    if (conf.const_we) begin
      mem[{conf.thread, conf.const_addr}] <= conf.const_data;
    end else if (en && ctrl.rf_we) begin
      mem[{ctrl.wr_thread, ctrl.rf_waddr}] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (en) begin
      rd_data <= mem[{ctrl.rd_thread, ctrl.rf_raddr}];
    end
  end

  // Constants arrive only while the pipeline is frozen
  a_const_vs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    !(conf.const_we && en && ctrl.rf_we))
    else $error("constant write collides with write-back");

endmodule

// File: logic/pe_top.sv
`timescale 1ns/1ps

module pe_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          en,
  input  logic          conf_req,
  input  logic [31:0]   conf_word,
  input  logic [15:0]   ina,
  input  logic [15:0]   inb,
  output logic          conf_ack,
  output logic [15:0]   outa,
  output logic [15:0]   outb,
  output logic [15:0]   fifo_data,
  output logic          fifo_we
);

  logic [pe_isa_pkg::DATA_W-1:0] rf_rdata;
  logic [pe_isa_pkg::DATA_W-1:0] alu_result;

  pe_conf_if conf_bus ();
  pe_ctrl_if ctrl_bus ();

  pe_conf_reader conf_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .conf_req  (conf_req),
    .conf_word (conf_word),
    .conf_ack  (conf_ack),
    .conf      (conf_bus)
  );

  pe_control control (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .conf  (conf_bus),
    .ctrl  (ctrl_bus)
  );

  pe_regfile regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .conf    (conf_bus),
    .ctrl    (ctrl_bus),
    .wr_data (alu_result),
    .rd_data (rf_rdata)
  );

  pe_alu alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .ina     (ina),
    .inb     (inb),
    .rf_data (rf_rdata),
    .ctrl    (ctrl_bus),
    .result  (alu_result)
  );

  pe_out_stage out_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .result    (alu_result),
    .conf      (conf_bus),
    .ctrl      (ctrl_bus),
    .outa      (outa),
    .outb      (outb),
    .fifo_data (fifo_data),
    .fifo_we   (fifo_we)
  );

endmodule

// File: sim.f
logic/pe_isa_pkg.sv
logic/pe_conf_pkg.sv
logic/pe_ctrl_if.sv
logic/pe_conf_if.sv
logic/pe_conf_reader.sv
logic/pe_control.sv
logic/pe_regfile.sv
logic/pe_alu.sv
logic/pe_out_stage.sv
logic/pe_top.sv
test/tb_pe.sv

// File: test/tb_pe.sv
`timescale 1ns/1ps

module tb_pe;

  logic        clk;
  logic        rst_n;
  logic        en;
  logic        conf_req;
  logic [31:0] conf_word;
  logic [15:0] ina;
  logic [15:0] inb;
  logic        conf_ack;
  logic [15:0] outa;
  logic [15:0] outb;
  logic [15:0] fifo_data;
  logic        fifo_we;

  // Reference model state per thread
  pe_isa_pkg::inst_t prog    [4][16];
  pe_isa_pkg::inst_t s_inst  [4];
  logic [15:0]       s_res   [4];
  logic [15:0]       m_rf    [4][8];
  logic [3:0]        m_pc    [4];
  logic [3:0]        m_max   [4];
  logic [3:0]        m_loop  [4];
  logic [7:0]        m_cnt   [4];
  logic [7:0]        m_limit [4];
  logic [15:0]       exp_outa;
  logic [15:0]       exp_outb;
  logic [15:0]       exp_fifo_data;
  logic              exp_fifo_q;
  logic [31:0]       rng;
  int                steps;
  int                err_cnt;
  int                cfg_cnt;

  pe_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .conf_req  (conf_req),
    .conf_word (conf_word),
    .ina       (ina),
    .inb       (inb),
    .conf_ack  (conf_ack),
    .outa      (outa),
    .outb      (outb),
    .fifo_data (fifo_data),
    .fifo_we   (fifo_we)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [15:0] alu_ref(input pe_isa_pkg::alu_op_e op,
                                          input logic [15:0] a, input logic [15:0] b);
    logic [31:0] prod;
    prod = {16'd0, a} * {16'd0, b};
    case (op)
      pe_isa_pkg::ADD: return a + b;
      pe_isa_pkg::SUB: return a - b;
      pe_isa_pkg::AND: return a & b;
      pe_isa_pkg::OR:  return a | b;
      pe_isa_pkg::XOR: return a ^ b;
      pe_isa_pkg::SHL: return a << b[3:0];
      pe_isa_pkg::SHR: return a >> b[3:0];
      pe_isa_pkg::MUL: return prod[15:0];
      default:         return 16'd0;
    endcase
  endfunction

  function automatic pe_isa_pkg::inst_t make_inst(input pe_isa_pkg::alu_op_e op,
      input logic b_rf, input logic [2:0] raddr, input logic we, input logic [2:0] waddr,
      input logic oa, input logic ob, input logic fw);
    pe_isa_pkg::inst_t ins;
    ins = '0;
    ins.op        = op;
    ins.b_from_rf = b_rf;
    ins.rf_raddr  = raddr;
    ins.rf_we     = we;
    ins.rf_waddr  = waddr;
    ins.out_a_en  = oa;
    ins.out_b_en  = ob;
    ins.fifo_we   = fw;
    return ins;
  endfunction

  // Four-phase master side of the configuration handshake
  task automatic handshake(input pe_conf_pkg::conf_word_t w);
    int n;
    conf_word <= w;
    conf_req  <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!conf_ack && n < 16);
    if (!conf_ack) begin
      err_cnt++;
      $display("conf_ack did not rise within 16 cycles of conf_req");
    end
    conf_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (conf_ack && n < 16);
    if (conf_ack) begin
      err_cnt++;
      $display("conf_ack did not fall within 16 cycles of conf_req dropping");
    end
    cfg_cnt++;
  endtask

  task automatic write_inst(input int t, input int a, input pe_isa_pkg::inst_t ins);
    pe_conf_pkg::conf_word_t w;
    w = '0;
    w.kind = pe_conf_pkg::INST;
    w.thread = 2'(t);
    w.payload.inst_view.addr = 4'(a);
    w.payload.inst_view.inst = ins;
    handshake(w);
    prog[t][a] = ins;
  endtask

  task automatic write_const(input int t, input int a, input logic [15:0] v);
    pe_conf_pkg::conf_word_t w;
    w = '0;
    w.kind = pe_conf_pkg::CONST;
    w.thread = 2'(t);
    w.payload.const_view.addr = 3'(a);
    w.payload.const_view.value = v;
    handshake(w);
    m_rf[t][a] = v;
  endtask

  task automatic write_loop(input int t, input int pmax, input int ploop, input int ign);
    pe_conf_pkg::conf_word_t w;
    w = '0;
    w.kind = pe_conf_pkg::LOOP;
    w.thread = 2'(t);
    w.payload.loop_view.pc_max = 4'(pmax);
    w.payload.loop_view.pc_loop = 4'(ploop);
    w.payload.loop_view.ignore_cnt = 8'(ign);
    handshake(w);
    m_max[t]   = 4'(pmax);
    m_loop[t]  = 4'(ploop);
    m_limit[t] = 8'(ign);
    m_cnt[t]   = 8'd0;
  endtask

  task automatic load_programs();
    logic [31:0]       r;
    pe_isa_pkg::inst_t ins;
    // Thread 0 walks all eight opcodes with B from inb
    for (int i = 0; i < 8; i++) begin
      write_inst(0, i, make_inst(pe_isa_pkg::alu_op_e'(i), 1'b0, 3'd0, 1'b0, 3'd0,
                                 (i % 2) == 0, (i % 2) == 1, i == 3 || i == 6));
    end
    write_loop(0, 7, 0, 0);
    // Thread 1 chains results through r1 and drops its first two FIFO results
    r = rand32();
    write_const(1, 0, r[15:0]);
    write_inst(1, 0, make_inst(pe_isa_pkg::ADD, 1'b1, 3'd0, 1'b1, 3'd1, 1'b1, 1'b0, 1'b0));
    write_inst(1, 1, make_inst(pe_isa_pkg::XOR, 1'b1, 3'd1, 1'b1, 3'd1, 1'b0, 1'b1, 1'b1));
    write_inst(1, 2, make_inst(pe_isa_pkg::SUB, 1'b1, 3'd1, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1));
    write_loop(1, 2, 0, 2);
    // Thread 2 loops 1..3 after a single pass through 0
    for (int i = 0; i < 4; i++) begin
      write_const(2, i, 16'(i + 1) * 16'h1111);
    end
    write_inst(2, 0, make_inst(pe_isa_pkg::ADD, 1'b1, 3'd0, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1));
    write_inst(2, 1, make_inst(pe_isa_pkg::SUB, 1'b1, 3'd1, 1'b0, 3'd0, 1'b0, 1'b1, 1'b1));
    write_inst(2, 2, make_inst(pe_isa_pkg::XOR, 1'b1, 3'd2, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1));
    write_inst(2, 3, make_inst(pe_isa_pkg::OR, 1'b1, 3'd3, 1'b0, 3'd0, 1'b0, 1'b1, 1'b1));
    write_loop(2, 3, 1, 0);
    // Thread 3 runs random instructions over a fully loaded slice
    for (int i = 0; i < 8; i++) begin
      r = rand32();
      write_const(3, i, r[15:0]);
    end
    for (int i = 0; i < 16; i++) begin
      r = rand32();
      ins = pe_isa_pkg::inst_t'(r[15:0]);
      ins.spare = '0;
      write_inst(3, i, ins);
    end
    write_loop(3, 15, 0, 0);
  endtask

  // One advance step covers the output of fetch k-3, the operands of fetch k-1 and fetch k
  task automatic model_step();
    int                t_out;
    int                t_dec;
    int                t_fet;
    pe_isa_pkg::inst_t ins;
    logic [15:0]       b;
    t_out = (steps + 1) % 4;
    t_dec = (steps + 3) % 4;
    t_fet = steps % 4;
    ins = s_inst[t_out];
    exp_fifo_data <= s_res[t_out];
    if (ins.out_a_en) begin
      exp_outa <= s_res[t_out];
    end
    if (ins.out_b_en) begin
      exp_outb <= s_res[t_out];
    end
    if (ins.rf_we) begin
      m_rf[t_out][ins.rf_waddr] = s_res[t_out];
    end
    if (!ins.fifo_we) begin
      exp_fifo_q <= 1'b0;
    end else if (m_cnt[t_out] == m_limit[t_out]) begin
      exp_fifo_q <= 1'b1;
    end else begin
      exp_fifo_q <= 1'b0;
      m_cnt[t_out] = m_cnt[t_out] + 8'd1;
    end
    ins = s_inst[t_dec];
    b = ins.b_from_rf ? m_rf[t_dec][ins.rf_raddr] : inb;
    s_res[t_dec] = alu_ref(ins.op, ina, b);
    s_inst[t_fet] = prog[t_fet][m_pc[t_fet]];
    if (m_pc[t_fet] == m_max[t_fet]) begin
      m_pc[t_fet] = m_loop[t_fet];
    end else begin
      m_pc[t_fet] = m_pc[t_fet] + 4'd1;
    end
  endtask

  task automatic run_cycles(input int n, input logic en_val);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      if (en) begin
        model_step();
        steps++;
      end
      r = rand32();
      en  <= en_val;
      ina <= r[15:0];
      inb <= r[31:16];
    end
  endtask

  a_reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !conf_ack && !fifo_we && outa == '0 && outb == '0 && fifo_data == '0)
    else begin
      err_cnt++;
      $display("FAIL reset: conf_ack %h fifo_we %h outa %h outb %h fifo_data %h expected 0",
               $sampled(conf_ack), $sampled(fifo_we), $sampled(outa), $sampled(outb),
               $sampled(fifo_data));
    end

  a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    conf_req && !conf_ack |=> conf_ack)
    else begin
      err_cnt++;
      $display("FAIL conf_ack: got %h expected %h", $sampled(conf_ack), 1'b1);
    end

  // Ack stays up until the master lets go of req
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    conf_req && conf_ack |=> conf_ack)
    else begin
      err_cnt++;
      $display("FAIL conf_ack: got %h expected %h", $sampled(conf_ack), 1'b1);
    end

  a_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
    !conf_req && conf_ack |=> !conf_ack)
    else begin
      err_cnt++;
      $display("FAIL conf_ack: got %h expected %h", $sampled(conf_ack), 1'b0);
    end

  a_ack_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !conf_req && !conf_ack |=> !conf_ack)
    else begin
      err_cnt++;
      $display("FAIL conf_ack: got %h expected %h", $sampled(conf_ack), 1'b0);
    end

  a_outa: assert property (@(posedge clk) disable iff (!rst_n) outa == exp_outa)
    else begin
      err_cnt++;
      $display("FAIL outa: got %h expected %h", $sampled(outa), $sampled(exp_outa));
    end

  a_outb: assert property (@(posedge clk) disable iff (!rst_n) outb == exp_outb)
    else begin
      err_cnt++;
      $display("FAIL outb: got %h expected %h", $sampled(outb), $sampled(exp_outb));
    end

  a_fifo_we: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_we == (exp_fifo_q && en))
    else begin
      err_cnt++;
      $display("FAIL fifo_we: got %h expected %h", $sampled(fifo_we),
               $sampled(exp_fifo_q && en));
    end

  a_fifo_data: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_we |-> fifo_data == exp_fifo_data)
    else begin
      err_cnt++;
      $display("FAIL fifo_data: got %h expected %h", $sampled(fifo_data),
               $sampled(exp_fifo_data));
    end

  // Frozen array keeps its outputs and writes nothing
  a_frozen_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !en |=> $stable(outa) && $stable(outb) && $stable(fifo_data))
    else begin
      err_cnt++;
      $display("an output changed across a step with en low");
    end

  a_frozen_no_write: assert property (@(posedge clk) disable iff (!rst_n) !en |-> !fifo_we)
    else begin
      err_cnt++;
      $display("FAIL fifo_we: got %h expected %h with en low", $sampled(fifo_we), 1'b0);
    end

  initial begin
    logic [31:0] r;
    rng = 32'd42;
    steps = 0;
    err_cnt = 0;
    cfg_cnt = 0;
    rst_n <= 1'b0;
    en <= 1'b0;
    conf_req <= 1'b0;
    conf_word <= '0;
    ina <= '0;
    inb <= '0;
    exp_outa <= '0;
    exp_outb <= '0;
    exp_fifo_data <= '0;
    exp_fifo_q <= 1'b0;
    for (int t = 0; t < 4; t++) begin
      s_inst[t] = '0;
      s_res[t] = '0;
      m_pc[t] = '0;
      m_max[t] = '0;
      m_loop[t] = '0;
      m_cnt[t] = '0;
      m_limit[t] = '0;
      for (int a = 0; a < 16; a++) begin
        prog[t][a] = '0;
      end
      for (int a = 0; a < 8; a++) begin
        m_rf[t][a] = '0;
      end
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    load_programs();
    run_cycles(240, 1'b1);
    // Random stretches with en low between bursts of steps
    for (int i = 0; i < 40; i++) begin
      r = rand32();
      run_cycles(1 + int'(r[2:0]), 1'b1);
      run_cycles(1 + int'(r[5:3]), 1'b0);
    end
    run_cycles(6, 1'b0);
    $display("errors: %0d, advance steps: %0d, configuration words: %0d",
             err_cnt, steps, cfg_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
